/* rvDecPkg.sv */
`default_nettype none

package rvDecPkg;

	// internal register ids, GPRs in 0..63 and specials above
	localparam int regIdWidth = 7;
	typedef logic [regIdWidth-1:0] regId_t;

	localparam regId_t grZero   = 7'h40;
	localparam regId_t grLink   = 7'h41;
	localparam regId_t grStack  = 7'h42;
	localparam regId_t grGlobal = 7'h43;
	// operand is taken from the immediate
	localparam regId_t grImm    = 7'h44;
	localparam regId_t grPc     = 7'h45;

	localparam int immWidth = 33;

	// micro-op class, zero is the invalid op
	typedef enum logic [5:0] {
		ucInvOp,
		ucMovMr,
		ucMovRm,
		ucJcmp,
		ucJsr,
		ucJmp,
		ucAlu3,
		ucShad3,
		ucShadQ3,
		ucMulDiv,
		ucMul3,
		ucLeaMr,
		ucMovIr,
		ucOpIxt
	} uCmd_e;

	typedef enum logic [5:0] {
		ixNone,
		// alu
		ixAdd, ixSub, ixAddSl, ixSubSl,
		ixSltSq, ixSltUq, ixSltSl, ixSltUl,
		ixXor, ixOr, ixAnd,
		// shifts, quad then word
		ixShldQ, ixShlrQ, ixSharQ,
		ixShld, ixShlr, ixShar,
		// branch compares
		ixQeq, ixQne, ixQlt, ixQge, ixQbl, ixQhs,
		// multiply and divide
		ixMulS, ixMulHs, ixMulHsu, ixMulHu,
		ixDivS, ixDivU, ixModS, ixModU,
		ixMul3S,
		ixMulHsl, ixMulHul, ixDivSl, ixDivUl, ixModSl, ixModUl,
		// system
		ixSyse, ixBreak, ixRte, ixSleep,
		ixLdix
	} uIx_e;

	typedef enum logic [3:0] {
		fmtZ,
		fmtRegReg,
		fmtRegImmReg,
		fmtLdDisp,
		fmtStDisp,
		fmtImmReg,
		fmtRegPc,
		fmtPcDisp,
		fmtInv
	} fmt_e;

	typedef enum logic [2:0] {
		ikNone,
		ikI,
		ikIu,
		ikS,
		ikB,
		ikJ,
		ikU
	} immKind_e;

	// access class, wide is for doubleword loads and stores
	typedef enum logic [2:0] {
		ctyScalar = 3'd0,
		ctyWide   = 3'd1
	} uCty_e;

	typedef struct packed {
		regId_t rs1Id;
		regId_t rs2Id;
		regId_t rdId;
	} regFields_t;

	typedef struct packed {
		uCmd_e    uCmd;
		uIx_e     uIx;
		fmt_e     fmt;
		immKind_e immKind;
		uCty_e    uCty;
		logic [2:0] memWidth;
	} decCtl_t;

	typedef struct packed {
		regId_t regN;
		regId_t regM;
		regId_t regO;
		regId_t regP;
		logic [immWidth-1:0] imm;
		uCmd_e  uCmd;
		// class in the top three bits, index below
		logic [8:0] uIxt;
		logic   immIsShort;
	} uOp_t;

endpackage

`default_nettype wire

/* rvRegMap.sv */
`timescale 1ns/10ps
`default_nettype none

module rvRegMap (
	input  wire logic [31:0]        instr,
	output rvDecPkg::regFields_t    regs
);

	import rvDecPkg::*;

	// x0..x3 land on the special registers, x14/x15 take ids 2 and 3
	function automatic regId_t mapReg(input logic [4:0] field);
		regId_t id;
		id = {2'b00, field};
		if (!field[4]) begin
			case (field[3:0])
				4'h0: id = grZero;
				4'h1: id = grLink;
				4'h2: id = grStack;
				4'h3: id = grGlobal;
				4'he: id = 7'd2;
				4'hf: id = 7'd3;
				default: id = {2'b00, field};
			endcase
		end
		return id;
	endfunction

	assign regs.rs1Id = mapReg(instr[19:15]);
	assign regs.rs2Id = mapReg(instr[24:20]);
	assign regs.rdId  = mapReg(instr[11:7]);

endmodule

`default_nettype wire

/* rvImmGen.sv */
`timescale 1ns/10ps
`default_nettype none

module rvImmGen (
	input  wire logic [31:0]                  instr,
	input  rvDecPkg::immKind_e                immKind,
	output logic [rvDecPkg::immWidth-1:0]     imm
);

	import rvDecPkg::*;

	logic sgn;

	assign sgn = instr[31];

	always_comb begin
		case (immKind)
			ikI: begin
				imm = {{21{sgn}}, instr[31:20]};
			end
			ikIu: begin
				imm = {21'b0, instr[31:20]};
			end
			ikS: begin
				imm = {{21{sgn}}, instr[31:25], instr[11:7]};
			end
			// branch offset, already divided by two
			ikB: begin
				imm = {{21{sgn}}, instr[31], instr[7], instr[30:25], instr[11:8]};
			end
			// jump offset, also halved
			ikJ: begin
				imm = {{13{sgn}}, instr[31], instr[19:12], instr[20], instr[30:21]};
			end
			ikU: begin
				imm = {sgn, instr[31:12], 12'h000};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rvOpDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module rvOpDecode #(
	parameter bit enableMulDiv  = 1'b1,
	parameter bit enableWordOps = 1'b1
) (
	input  wire logic [31:0]     instr,
	output rvDecPkg::decCtl_t    ctl
);

	import rvDecPkg::*;

	localparam decCtl_t invCtl = '{
		uCmd: ucInvOp,
		uIx: ixNone,
		fmt: fmtInv,
		immKind: ikNone,
		uCty: ctyScalar,
		memWidth: 3'b000
	};

	logic [2:0] funct3;
	logic       alt;
	logic       isMulDiv;
	logic       rdIsZero;

	assign funct3   = instr[14:12];
	assign alt      = instr[30];
	assign isMulDiv = (instr[31:25] == 7'h01);
	assign rdIsZero = (instr[11:7] == 5'h00);

	// shared alu/shift table, word selects the 32-bit forms
	function automatic decCtl_t aluCtl(input decCtl_t base, input logic [2:0] f3,
			input logic subOk, input logic word);
		decCtl_t c;
		c = base;
		c.uCmd = ucAlu3;
		case (f3)
			3'b000: begin
				if (subOk && alt)
					c.uIx = word ? ixSubSl : ixSub;
				else
					c.uIx = word ? ixAddSl : ixAdd;
			end
			3'b001: begin
				c.uCmd = word ? ucShad3 : ucShadQ3;
				c.uIx  = word ? ixShld : ixShldQ;
			end
			3'b010: c.uIx = word ? ixSltSl : ixSltSq;
			3'b011: c.uIx = word ? ixSltUl : ixSltUq;
			3'b100: c.uIx = ixXor;
			3'b101: begin
				c.uCmd = word ? ucShad3 : ucShadQ3;
				if (alt)
					c.uIx = word ? ixShar : ixSharQ;
				else
					c.uIx = word ? ixShlr : ixShlrQ;
			end
			3'b110: c.uIx = ixOr;
			default: c.uIx = ixAnd;
		endcase
		return c;
	endfunction

	function automatic decCtl_t mulCtl(input decCtl_t base, input logic [2:0] f3,
			input logic word);
		decCtl_t c;
		c = base;
		c.uCmd = ucMulDiv;
		case (f3)
			3'b000: begin
				c.uCmd = word ? ucMul3 : ucMulDiv;
				c.uIx  = word ? ixMul3S : ixMulS;
			end
			3'b001: c.uIx = word ? ixMulHsl : ixMulHs;
			// no separate word form for the mixed-sign high multiply
			3'b010: c.uIx = ixMulHsu;
			3'b011: c.uIx = word ? ixMulHul : ixMulHu;
			3'b100: c.uIx = word ? ixDivSl : ixDivS;
			3'b101: c.uIx = word ? ixDivUl : ixDivU;
			3'b110: c.uIx = word ? ixModSl : ixModS;
			default: c.uIx = word ? ixModUl : ixModU;
		endcase
		return c;
	endfunction

	always_comb begin
		ctl = invCtl;
		case (instr[6:2])
			5'b00000: begin
				ctl.uCmd     = ucMovMr;
				ctl.fmt      = fmtLdDisp;
				ctl.immKind  = ikI;
				ctl.memWidth = funct3;
				ctl.uCty     = (funct3 == 3'b011) ? ctyWide : ctyScalar;
			end
			5'b01000: begin
				ctl.uCmd     = ucMovRm;
				ctl.fmt      = fmtStDisp;
				ctl.immKind  = ikS;
				ctl.memWidth = funct3;
				ctl.uCty     = (funct3 == 3'b011) ? ctyWide : ctyScalar;
			end
			5'b11000: begin
				ctl.uCmd    = ucJcmp;
				ctl.fmt     = fmtRegPc;
				ctl.immKind = ikB;
				case (funct3)
					3'b001: ctl.uIx = ixQne;
					3'b100: ctl.uIx = ixQlt;
					3'b101: ctl.uIx = ixQge;
					3'b110: ctl.uIx = ixQbl;
					3'b111: ctl.uIx = ixQhs;
					// 010 and 011 fall back to equal
					default: ctl.uIx = ixQeq;
				endcase
			end
			5'b11001: begin
				ctl.uCmd    = rdIsZero ? ucJmp : ucJsr;
				ctl.fmt     = fmtRegImmReg;
				ctl.immKind = ikI;
			end
			5'b11011: begin
				ctl.uCmd    = rdIsZero ? ucJmp : ucJsr;
				ctl.fmt     = fmtPcDisp;
				ctl.immKind = ikJ;
			end
			5'b00100: begin
				ctl.fmt     = fmtRegImmReg;
				ctl.immKind = ikI;
				ctl         = aluCtl(ctl, funct3, 1'b0, 1'b0);
			end
			5'b01100: begin
				ctl.fmt = fmtRegReg;
				if (!isMulDiv)
					ctl = aluCtl(ctl, funct3, 1'b1, 1'b0);
				else if (enableMulDiv)
					ctl = mulCtl(ctl, funct3, 1'b0);
			end
			5'b00110: begin
				if (enableWordOps) begin
					ctl.fmt     = fmtRegImmReg;
					ctl.immKind = ikI;
					ctl         = aluCtl(ctl, funct3, 1'b0, 1'b1);
				end
			end
			5'b01110: begin
				if (enableWordOps) begin
					ctl.fmt = fmtRegReg;
					if (!isMulDiv)
						ctl = aluCtl(ctl, funct3, 1'b1, 1'b1);
					else if (enableMulDiv)
						ctl = mulCtl(ctl, funct3, 1'b1);
				end
			end
			5'b11100: begin
				if (funct3 == 3'b000) begin
					ctl.uCmd = ucOpIxt;
					ctl.fmt  = fmtZ;
					case (instr[23:20])
						4'h0: ctl.uIx = ixSyse;
						4'h1: ctl.uIx = ixBreak;
						4'h2: ctl.uIx = ixRte;
						4'h5: ctl.uIx = ixSleep;
						default: ctl = invCtl;
					endcase
				end
			end
			5'b00101: begin
				ctl.uCmd    = ucLeaMr;
				ctl.fmt     = fmtPcDisp;
				ctl.immKind = ikU;
			end
			5'b01101: begin
				ctl.uCmd    = ucMovIr;
				ctl.uIx     = ixLdix;
				ctl.fmt     = fmtImmReg;
				ctl.immKind = ikU;
			end
			default: begin
				ctl = invCtl;
			end
		endcase

		// compressed or longer encodings are not handled here
		if (instr[1:0] != 2'b11 || ctl.uCmd == ucInvOp)
			ctl = invCtl;
	end

endmodule

`default_nettype wire

/* rvOperandSel.sv */
`timescale 1ns/10ps
`default_nettype none

module rvOperandSel (
	input  rvDecPkg::decCtl_t                 ctl,
	input  rvDecPkg::regFields_t              regs,
	input  wire logic [rvDecPkg::immWidth-1:0] imm,
	input  wire logic [31:0]                  instr,
	input  wire logic                         userMode,
	output rvDecPkg::uOp_t                    next
);

	import rvDecPkg::*;

	logic userReject;

	// user code may not write x4
	assign userReject = userMode && (instr[11:7] == 5'h04);

	always_comb begin
		next            = '0;
		next.regN       = grZero;
		next.regM       = grZero;
		next.regO       = grZero;
		next.regP       = grZero;
		next.uCmd       = ctl.uCmd;
		next.uIxt       = {ctl.uCty, ctl.uIx};
		next.immIsShort = 1'b0;

		case (ctl.fmt)
			fmtRegReg: begin
				next.regM = regs.rs1Id;
				next.regO = regs.rs2Id;
				next.regN = regs.rdId;
				next.imm  = {21'b0, instr[31:20]};
			end
			fmtRegImmReg, fmtLdDisp: begin
				next.regM = regs.rs1Id;
				next.regO = grImm;
				next.regN = regs.rdId;
				next.imm  = imm;
			end
			// store data goes out on the N/P ports
			fmtStDisp: begin
				next.regM = regs.rs1Id;
				next.regO = grImm;
				next.regN = regs.rs2Id;
				next.imm  = imm;
			end
			fmtRegPc: begin
				next.regM = regs.rs1Id;
				next.regO = regs.rs2Id;
				next.imm  = imm;
			end
			fmtPcDisp: begin
				next.regM = grPc;
				next.regO = grImm;
				next.regN = regs.rdId;
				next.imm  = imm;
			end
			fmtImmReg: begin
				next.regM = regs.rdId;
				next.regO = grImm;
				next.regN = regs.rdId;
				next.imm  = imm;
			end
			default: begin
				next.imm = '0;
			end
		endcase

		// memory index packs width low bits, a gap, then the sign bit
		if (ctl.fmt == fmtLdDisp || ctl.fmt == fmtStDisp)
			next.uIxt = {ctl.uCty, ctl.memWidth[1:0], 1'b0, ctl.memWidth[2], 2'b00};

		next.regP = next.regN;

		if (userReject) begin
			next.uCmd = ucInvOp;
			next.uIxt = '0;
			next.imm  = '0;
			next.regN = grZero;
			next.regM = grZero;
			next.regO = grZero;
			next.regP = grZero;
		end
	end

endmodule

`default_nettype wire

/* rvDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rvDecoder #(
	parameter bit enableMulDiv  = 1'b1,
	parameter bit enableWordOps = 1'b1
) (
	input  wire logic       clock,
	input  wire logic       arstN,
	input  wire logic       instrValid,
	input  wire logic [31:0] instr,
	input  wire logic       hold,
	input  wire logic       userMode,
	output logic            uOpValid,
	output rvDecPkg::uOp_t  uOp
);

	import rvDecPkg::*;

	regFields_t          regs;
	decCtl_t             ctl;
	logic [immWidth-1:0] imm;
	uOp_t                nextUOp;

	rvRegMap regMap (
		.instr(instr),
		.regs(regs)
	);

	rvOpDecode #(
		.enableMulDiv(enableMulDiv),
		.enableWordOps(enableWordOps)
	) opDecode (
		.instr(instr),
		.ctl(ctl)
	);

	rvImmGen immGen (
		.instr(instr),
		.immKind(ctl.immKind),
		.imm(imm)
	);

	rvOperandSel operandSel (
		.ctl(ctl),
		.regs(regs),
		.imm(imm),
		.instr(instr),
		.userMode(userMode),
		.next(nextUOp)
	);

	// output stage, hold freezes both valid and payload
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			uOpValid <= 1'b0;
			uOp      <= '0;
		end else if (!hold) begin
			uOpValid <= instrValid;
			uOp      <= nextUOp;
		end
	end

endmodule

`default_nettype wire

/* tbRvDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tbRvDecoder;

	import rvDecPkg::*;

	// the directed tests need under 200 cycles, so this leaves a wide margin
	localparam int maxCycles = 2000;

	logic        clock;
	logic        arstN;
	logic        instrValid;
	logic [31:0] instr;
	logic        hold;
	logic        userMode;
	logic        uOpValid;
	uOp_t        uOp;

	integer seed;
	int     cycles = 0;

	rvDecoder #(
		.enableMulDiv(1'b1),
		.enableWordOps(1'b1)
	) DUT (
		.clock(clock),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.hold(hold),
		.userMode(userMode),
		.uOpValid(uOpValid),
		.uOp(uOp)
	);

	initial begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= maxCycles)
			failRun("Timeout because the tests did not finish within the cycle limit");
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// instruction encoders
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	// reference register remap
	function automatic regId_t expReg(input logic [4:0] x);
		case (x)
			5'd0: return grZero;
			5'd1: return grLink;
			5'd2: return grStack;
			5'd3: return grGlobal;
			5'd14: return 7'd2;
			5'd15: return 7'd3;
			default: return {2'b00, x};
		endcase
	endfunction

	function automatic logic [immWidth-1:0] sext12(input logic [11:0] v);
		return {{21{v[11]}}, v};
	endfunction

	function automatic uOp_t mkUop(input uCmd_e cmd, input uCty_e cty, input logic [5:0] ix,
			input regId_t regM, input regId_t regO, input regId_t regN,
			input logic [immWidth-1:0] imm);
		uOp_t u;
		u.regN       = regN;
		u.regM       = regM;
		u.regO       = regO;
		u.regP       = regN;
		u.imm        = imm;
		u.uCmd       = cmd;
		u.uIxt       = {cty, ix};
		u.immIsShort = 1'b0;
		return u;
	endfunction

	function automatic uOp_t invUop();
		return mkUop(ucInvOp, ctyScalar, 6'd0, grZero, grZero, grZero, '0);
	endfunction

	// expected alu or shift op from funct3, bit 30 and the group
	function automatic void aluRef(input logic [2:0] f3, input logic alt, input logic isReg,
			input logic word, output uCmd_e cmd, output uIx_e ix);
		cmd = ucAlu3;
		case (f3)
			3'd0: begin
				if (isReg && alt)
					ix = word ? ixSubSl : ixSub;
				else
					ix = word ? ixAddSl : ixAdd;
			end
			3'd1: begin
				cmd = word ? ucShad3 : ucShadQ3;
				ix  = word ? ixShld : ixShldQ;
			end
			3'd2: ix = word ? ixSltSl : ixSltSq;
			3'd3: ix = word ? ixSltUl : ixSltUq;
			3'd4: ix = ixXor;
			3'd5: begin
				cmd = word ? ucShad3 : ucShadQ3;
				if (alt)
					ix = word ? ixShar : ixSharQ;
				else
					ix = word ? ixShlr : ixShlrQ;
			end
			3'd6: ix = ixOr;
			default: ix = ixAnd;
		endcase
	endfunction

	// drive one instruction and check it one cycle later
	task automatic decodeAndCheck(input logic [31:0] word, input logic user, input uOp_t exp);
		instrValid = 1'b1;
		instr      = word;
		userMode   = user;
		hold       = 1'b0;
		@(posedge clock);
		#1;
		assert (uOpValid === 1'b1) else
			failRun($sformatf("Mismatch uOpValid expected %h got %h", 1'b1, uOpValid));
		assert (uOp === exp) else
			failRun($sformatf("Mismatch uOp for instr %h expected %h got %h", word, exp, uOp));
	endtask

	task automatic checkReset();
		assert (uOpValid === 1'b0) else
			failRun($sformatf("Mismatch uOpValid expected %h got %h", 1'b0, uOpValid));
		assert (uOp === '0) else
			failRun($sformatf("Mismatch uOp expected %h got %h", {$bits(uOp_t){1'b0}}, uOp));
	endtask

	task automatic checkAluShift();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [11:0] imm12;
		logic [6:0]  f7;
		logic [6:0]  op;
		logic        alt;
		logic        word;
		logic        isReg;
		uCmd_e       cmd;
		uIx_e        ix;
		int          i;
		for (i = 0; i < 64; i++) begin
			r     = $random(seed);
			r2    = $random(seed);
			rs1   = r[4:0];
			rs2   = r[9:5];
			rd    = r[14:10];
			f3    = r[17:15];
			isReg = r[18];
			word  = r[19];
			imm12 = r2[11:0];
			alt   = isReg ? r[20] : imm12[10];
			f7    = {1'b0, alt, 5'b00000};
			op    = isReg ? (word ? 7'h3b : 7'h33) : (word ? 7'h1b : 7'h13);
			aluRef(f3, alt, isReg, word, cmd, ix);
			if (isReg)
				decodeAndCheck(rType(f7, rs2, rs1, f3, rd, op), 1'b0,
					mkUop(cmd, ctyScalar, ix, expReg(rs1), expReg(rs2), expReg(rd),
						{21'b0, f7, rs2}));
			else
				decodeAndCheck(iType(imm12, rs1, f3, rd, op), 1'b0,
					mkUop(cmd, ctyScalar, ix, expReg(rs1), grImm, expReg(rd), sext12(imm12)));
		end
		// logical versus arithmetic right shift by bit 30
		decodeAndCheck(iType(12'h003, 5'd9, 3'd5, 5'd10, 7'h13), 1'b0,
			mkUop(ucShadQ3, ctyScalar, ixShlrQ, 7'd9, grImm, 7'd10, sext12(12'h003)));
		decodeAndCheck(iType(12'h403, 5'd9, 3'd5, 5'd10, 7'h13), 1'b0,
			mkUop(ucShadQ3, ctyScalar, ixSharQ, 7'd9, grImm, 7'd10, sext12(12'h403)));
	endtask

	task automatic checkRemap();
		logic [4:0] x;
		int         i;
		for (i = 0; i < 32; i++) begin
			x = i[4:0];
			decodeAndCheck(rType(7'h00, ~x, x, 3'd0, x, 7'h33), 1'b0,
				mkUop(ucAlu3, ctyScalar, ixAdd, expReg(x), expReg(~x), expReg(x),
					{21'b0, 7'h00, ~x}));
		end
	endtask

	task automatic checkMemFlow();
		logic [31:0] r;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [11:0] imm12;
		logic [12:0] offB;
		logic [20:0] offJ;
		logic [2:0]  w;
		uCty_e       cty;
		uIx_e        ix;
		int          i;
		for (i = 0; i < 7; i++) begin
			r     = $random(seed);
			rs1   = r[4:0];
			rd    = r[9:5];
			imm12 = r[31:20];
			w     = i[2:0];
			cty   = (w == 3'd3) ? ctyWide : ctyScalar;
			decodeAndCheck(iType(imm12, rs1, w, rd, 7'h03), 1'b0,
				mkUop(ucMovMr, cty, {w[1:0], 1'b0, w[2], 2'b00}, expReg(rs1), grImm,
					expReg(rd), sext12(imm12)));
		end
		for (i = 0; i < 4; i++) begin
			r     = $random(seed);
			rs1   = r[4:0];
			rs2   = r[9:5];
			imm12 = r[31:20];
			w     = i[2:0];
			cty   = (w == 3'd3) ? ctyWide : ctyScalar;
			decodeAndCheck(sType(imm12, rs2, rs1, w), 1'b0,
				mkUop(ucMovRm, cty, {w[1:0], 1'b0, w[2], 2'b00}, expReg(rs1), grImm,
					expReg(rs2), sext12(imm12)));
		end
		for (i = 0; i < 8; i++) begin
			r    = $random(seed);
			rs1  = r[4:0];
			rs2  = r[9:5];
			offB = {r[31:20], 1'b0};
			w    = i[2:0];
			case (w)
				3'd1: ix = ixQne;
				3'd4: ix = ixQlt;
				3'd5: ix = ixQge;
				3'd6: ix = ixQbl;
				3'd7: ix = ixQhs;
				default: ix = ixQeq;
			endcase
			// offset is carried in halfword units
			decodeAndCheck(bType(offB, rs2, rs1, w), 1'b0,
				mkUop(ucJcmp, ctyScalar, ix, expReg(rs1), expReg(rs2), grZero,
					{{21{offB[12]}}, offB[12:1]}));
		end
		r    = $random(seed);
		offJ = {r[31:12], 1'b0};
		rd   = {r[4:1], 1'b1};
		decodeAndCheck(jType(offJ, 5'd0), 1'b0,
			mkUop(ucJmp, ctyScalar, 6'd0, grPc, grImm, grZero, {{13{offJ[20]}}, offJ[20:1]}));
		decodeAndCheck(jType(offJ, rd), 1'b0,
			mkUop(ucJsr, ctyScalar, 6'd0, grPc, grImm, expReg(rd), {{13{offJ[20]}}, offJ[20:1]}));
		rs1   = r[9:5];
		imm12 = r[31:20];
		decodeAndCheck(iType(imm12, rs1, 3'd0, 5'd0, 7'h67), 1'b0,
			mkUop(ucJmp, ctyScalar, 6'd0, expReg(rs1), grImm, grZero, sext12(imm12)));
		decodeAndCheck(iType(imm12, rs1, 3'd0, rd, 7'h67), 1'b0,
			mkUop(ucJsr, ctyScalar, 6'd0, expReg(rs1), grImm, expReg(rd), sext12(imm12)));
		// lui and auipc
		decodeAndCheck({r[31:12], rd, 7'h37}, 1'b0,
			mkUop(ucMovIr, ctyScalar, ixLdix, expReg(rd), grImm, expReg(rd),
				{r[31], r[31:12], 12'h000}));
		decodeAndCheck({r[31:12], rd, 7'h17}, 1'b0,
			mkUop(ucLeaMr, ctyScalar, 6'd0, grPc, grImm, expReg(rd),
				{r[31], r[31:12], 12'h000}));
	endtask

	task automatic checkMulSys();
		logic [31:0] r;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [2:0]  f3;
		uIx_e        qIx;
		uIx_e        wIx;
		int          i;
		for (i = 0; i < 8; i++) begin
			r   = $random(seed);
			rs1 = r[4:0];
			rs2 = r[9:5];
			rd  = r[14:10];
			f3  = i[2:0];
			case (f3)
				3'd0: begin
					qIx = ixMulS;
					wIx = ixMul3S;
				end
				3'd1: begin
					qIx = ixMulHs;
					wIx = ixMulHsl;
				end
				3'd2: begin
					qIx = ixMulHsu;
					wIx = ixMulHsu;
				end
				3'd3: begin
					qIx = ixMulHu;
					wIx = ixMulHul;
				end
				3'd4: begin
					qIx = ixDivS;
					wIx = ixDivSl;
				end
				3'd5: begin
					qIx = ixDivU;
					wIx = ixDivUl;
				end
				3'd6: begin
					qIx = ixModS;
					wIx = ixModSl;
				end
				default: begin
					qIx = ixModU;
					wIx = ixModUl;
				end
			endcase
			decodeAndCheck(rType(7'h01, rs2, rs1, f3, rd, 7'h33), 1'b0,
				mkUop(ucMulDiv, ctyScalar, qIx, expReg(rs1), expReg(rs2), expReg(rd),
					{21'b0, 7'h01, rs2}));
			decodeAndCheck(rType(7'h01, rs2, rs1, f3, rd, 7'h3b), 1'b0,
				mkUop((f3 == 3'd0) ? ucMul3 : ucMulDiv, ctyScalar, wIx, expReg(rs1),
					expReg(rs2), expReg(rd), {21'b0, 7'h01, rs2}));
		end
		// ecall, ebreak, mret, wfi
		decodeAndCheck(32'h00000073, 1'b0,
			mkUop(ucOpIxt, ctyScalar, ixSyse, grZero, grZero, grZero, '0));
		decodeAndCheck(32'h00100073, 1'b0,
			mkUop(ucOpIxt, ctyScalar, ixBreak, grZero, grZero, grZero, '0));
		decodeAndCheck(32'h30200073, 1'b0,
			mkUop(ucOpIxt, ctyScalar, ixRte, grZero, grZero, grZero, '0));
		decodeAndCheck(32'h10500073, 1'b0,
			mkUop(ucOpIxt, ctyScalar, ixSleep, grZero, grZero, grZero, '0));
	endtask

	task automatic checkInvalid();
		logic [31:0] r;
		r = $random(seed);
		decodeAndCheck({r[31:7], 7'h7f}, 1'b0, invUop());
		// add with a compressed-style low pair
		decodeAndCheck(rType(7'h00, 5'd6, 5'd7, 3'd0, 5'd8, 7'h31), 1'b0, invUop());
		decodeAndCheck(iType(r[31:20], 5'd5, 3'd0, 5'd4, 7'h13), 1'b1, invUop());
		decodeAndCheck(iType(r[31:20], 5'd5, 3'd0, 5'd4, 7'h13), 1'b0,
			mkUop(ucAlu3, ctyScalar, ixAdd, 7'd5, grImm, 7'd4, sext12(r[31:20])));
	endtask

	task automatic checkTiming();
		uOp_t expA;
		uOp_t expC;
		int   i;
		expA = mkUop(ucAlu3, ctyScalar, ixAdd, 7'd6, grImm, 7'd5, sext12(12'h123));
		expC = mkUop(ucAlu3, ctyScalar, ixXor, 7'd7, grImm, 7'd8, sext12(12'h7f0));
		decodeAndCheck(iType(12'h123, 5'd6, 3'd0, 5'd5, 7'h13), 1'b0, expA);
		// stalled stage keeps its output while a new instruction waits
		hold       = 1'b1;
		instrValid = 1'b1;
		instr      = iType(12'h7f0, 5'd7, 3'd4, 5'd8, 7'h13);
		for (i = 0; i < 3; i++) begin
			@(posedge clock);
			#1;
			assert (uOpValid === 1'b1) else
				failRun($sformatf("Mismatch uOpValid expected %h got %h", 1'b1, uOpValid));
			assert (uOp === expA) else
				failRun($sformatf("Mismatch uOp expected %h got %h", expA, uOp));
		end
		decodeAndCheck(iType(12'h7f0, 5'd7, 3'd4, 5'd8, 7'h13), 1'b0, expC);
		instrValid = 1'b0;
		hold       = 1'b0;
		@(posedge clock);
		#1;
		assert (uOpValid === 1'b0) else
			failRun($sformatf("Mismatch uOpValid expected %h got %h", 1'b0, uOpValid));
		// an empty stage stays empty while stalled
		hold       = 1'b1;
		instrValid = 1'b1;
		instr      = iType(12'h123, 5'd6, 3'd0, 5'd5, 7'h13);
		@(posedge clock);
		#1;
		assert (uOpValid === 1'b0) else
			failRun($sformatf("Mismatch uOpValid expected %h got %h", 1'b0, uOpValid));
		assert (uOp === expC) else
			failRun($sformatf("Mismatch uOp expected %h got %h", expC, uOp));
	endtask

	initial begin
		seed       = 32'hde537a46;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		hold       = 1'b0;
		userMode   = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		arstN = 1'b1;
		checkReset();
		checkAluShift();
		checkRemap();
		checkMemFlow();
		checkMulSys();
		checkInvalid();
		checkTiming();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
rvDecPkg.sv
rvRegMap.sv
rvImmGen.sv
rvOpDecode.sv
rvOperandSel.sv
rvDecoder.sv
tbRvDecoder.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tbRvDecoder
DUT_TOP   ?= rvDecoder
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(DUT_TOP) $(VFLAGS)

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) $(VFLAGS)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
